/* perf_board_top.f */
perf_board_pkg.sv
rate_divider.sv
run_control.sv
event_counters.sv
seg_display.sv
perf_board_top.sv
perf_board_props.sv
tb_perf_board.sv

/* tb_perf_board.sv */
module tb_perf_board
    import perf_board_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int   TIMEOUT = 300;                  // clk cycles per wait loop
    localparam int   WINDOW  = 4 * RATE_PERIOD_0;
    localparam int   PERIODS [4] = '{RATE_PERIOD_0, RATE_PERIOD_1, RATE_PERIOD_2, RATE_PERIOD_3};
    localparam seg_t HEX_SEG [16] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
                                      8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};

    logic        clk = 1'b0;
    logic        rst;
    logic        resume;
    logic        halt;
    logic [15:0] swt;
    logic [5:0]  ev;                                 // jump branch taken nop bp_hit bp_miss
    word_t       core_display;
    logic        core_en;
    seg_t        seg_n;
    seg_t        an_n;

    logic [15:0] lfsr = 16'd27324;
    word_t       mcnt [7];                           // model counts, slot 0 is cycles
    logic        halted_m;
    logic        resume_prev;
    logic [1:0]  rate_prev;
    logic        tick_m;
    logic        exp_en;
    int          next_tick;                          // cycle of the next expected tick
    int          halted_cyc;
    int          en_count;
    int          first_en;
    int          cyc;
    int          base;
    int          mismatches = 0;
    int          timeouts = 0;
    word_t       word;

    perf_board_top i_perf_board_top (
        .clk          (clk),
        .rst          (rst),
        .resume       (resume),
        .swt          (swt),
        .halt         (halt),
        .is_jump      (ev[0]),
        .is_branch    (ev[1]),
        .taken        (ev[2]),
        .is_nop       (ev[3]),
        .bp_hit       (ev[4]),
        .bp_miss      (ev[5]),
        .core_display (core_display),
        .core_en      (core_en),
        .seg_n        (seg_n),
        .an_n         (an_n)
    );

    always #10 clk = ~clk;

    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // taps 16 14 13 11
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [4:0] seg_to_nibble(input seg_t s);   // {valid, nibble}
        for (int i = 0; i < 16; i++) begin
            if (HEX_SEG[i] == s) begin
                return {1'b1, 4'(i)};
            end
        end
        return 5'h00;
    endfunction

    // ==============================
    // core model, sampled mid-cycle
    // ==============================
    always @(negedge clk) begin
        if (rst) begin
            if (core_en) begin
                $display("MISMATCH at %0t: core_en high during reset", $time);
                mismatches++;
            end
            for (int i = 0; i < 7; i++) begin
                mcnt[i] = '0;
            end
            halted_m    = 1'b0;
            resume_prev = 1'b0;
            rate_prev   = swt[1:0];
            next_tick   = PERIODS[swt[1:0]];
            halted_cyc  = 0;
            en_count    = 0;
            first_en    = -1;
            cyc         = 0;
        end else begin
            tick_m = (cyc == next_tick);
            exp_en = tick_m && !halted_m;
            if (core_en !== exp_en) begin
                $display("MISMATCH at %0t: core_en %b, expected %b", $time, core_en, exp_en);
                mismatches++;
            end
            if (core_en) begin
                en_count++;
                if (first_en < 0) begin
                    first_en = cyc;
                end
                mcnt[0]++;
                for (int i = 1; i < 7; i++) begin
                    mcnt[i] = mcnt[i] + ev[i-1];
                end
            end
            if (!halted_m) begin
                halted_m = core_en && halt;
            end else if (resume && !resume_prev) begin
                halted_m = 1'b0;                         // resume edge
            end
            if (swt[1:0] != rate_prev) begin
                next_tick = cyc + 1 + PERIODS[swt[1:0]];  // new rate counts from zero
            end else if (tick_m) begin
                next_tick = cyc + PERIODS[swt[1:0]];
            end
            rate_prev   = swt[1:0];
            halted_cyc  = halted_m ? halted_cyc + 1 : 0;
            resume_prev = resume;
            cyc++;
        end
    end

    task automatic run_cycles(input int n, input logic wild);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #2;
            ev = 6'(rand_bits(6));
            if (wild) begin
                halt         = (rand_bits(5) == 0);
                resume       = (halted_cyc >= 3) && (rand_bits(2) == 0);
                core_display = rand_bits(32);
                if (rand_bits(6) == 0) begin
                    swt[1:0] = 2'(rand_bits(2));         // rate change
                end
            end
        end
    endtask

    task automatic stop_core();
        int t;
        t    = 0;
        halt = 1'b1;
        while (!halted_m && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!halted_m) begin
            $display("core did not halt within %0d cycles", TIMEOUT);
            timeouts++;
        end
        @(posedge clk);
        #2;
        halt = 1'b0;
    endtask

    task automatic wait_anode(input seg_t pat, input logic want);
        int t;
        t = 0;
        while (((an_n == pat) != want) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if ((an_n == pat) != want) begin
            $display("display scan stalled near anode pattern %h", pat);
            timeouts++;
        end
    endtask

    task automatic read_scan(output word_t val);
        logic [4:0] dec;
        val = '0;
        wait_anode(8'hfe, 1'b0);                         // skip a stale digit 0
        wait_anode(8'hfe, 1'b1);
        for (int d = 0; d < NUM_DIGITS; d++) begin
            if (d > 0) begin
                wait_anode(~(8'h01 << (d - 1)), 1'b0);   // next digit update
            end
            if (an_n != ~(8'h01 << d)) begin
                $display("MISMATCH at %0t: anode %h on digit %0d", $time, an_n, d);
                mismatches++;
            end
            dec = seg_to_nibble(seg_n);
            if (!dec[4]) begin
                $display("MISMATCH at %0t: bad segment pattern %h", $time, seg_n);
                mismatches++;
            end
            val[4*d +: 4] = dec[3:0];
        end
    endtask

    task automatic check_word(input disp_sel_t sel, input word_t exp);
        @(posedge clk);
        #2;
        swt[5:2] = sel;
        read_scan(word);
        if (word !== exp) begin
            $display("MISMATCH at %0t: select %0d shows %h, expected %h", $time, sel, word, exp);
            mismatches++;
        end
    endtask

    initial begin
        rst          = 1'b1;
        resume       = 1'b0;
        halt         = 1'b0;
        ev           = '0;
        core_display = '0;
        swt          = {10'd0, DISP_CYCLE, 2'd0};     // slowest rate
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // ==============================
        // reset state and rates
        // ==============================
        for (int s = 1; s <= 7; s++) begin
            check_word(disp_sel_t'(s), '0);
        end
        if (first_en < RATE_PERIOD_0 - 1) begin
            $display("MISMATCH at %0t: first core_en in cycle %0d", $time, first_en);
            mismatches++;
        end
        @(posedge clk);
        #2;
        swt[5:2] = DISP_CORE;
        for (int r = 0; r < 4; r++) begin
            swt[1:0] = 2'(r);
            run_cycles(1, 1'b0);
            base = en_count;
            run_cycles(WINDOW, 1'b0);
            if ((en_count - base) < WINDOW / PERIODS[r] - 1 ||
                (en_count - base) > WINDOW / PERIODS[r] + 1) begin
                $display("MISMATCH at %0t: rate %0d gave %0d steps", $time, r, en_count - base);
                mismatches++;
            end
        end

        // ==============================
        // halt and resume
        // ==============================
        swt[1:0] = 2'd2;
        stop_core();
        resume = 1'b1;
        base   = en_count;
        run_cycles(40, 1'b0);
        if (en_count == base) begin
            $display("MISMATCH at %0t: no core_en after resume", $time);
            mismatches++;
        end
        stop_core();                                     // resume still held high
        base = en_count;
        run_cycles(40, 1'b0);
        if (en_count != base) begin
            $display("MISMATCH at %0t: held resume restarted the core", $time);
            mismatches++;
        end
        resume = 1'b0;
        run_cycles(3, 1'b0);
        resume = 1'b1;
        run_cycles(1, 1'b0);
        resume = 1'b0;

        // ==============================
        // random run and display reads
        // ==============================
        run_cycles(2000, 1'b1);
        resume = 1'b0;
        stop_core();
        for (int s = 1; s <= 7; s++) begin
            check_word(disp_sel_t'(s), mcnt[s-1]);
        end
        @(posedge clk);
        #2;
        core_display = rand_bits(32);
        check_word(DISP_CORE, core_display);
        for (int s = 8; s <= 15; s++) begin
            check_word(disp_sel_t'(s), core_display);
        end

        $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* perf_board_props.sv */
module perf_board_props
    import perf_board_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic core_en,
    input logic halt,
    input logic resume,
    input seg_t an_n
);

    timeunit 1ns;
    timeprecision 1ps;

    logic scan_live;    // set once any digit has lit
    logic resume_seen;  // resume level one cycle back
    logic stopped;      // halt step seen, no resume edge since

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_live <= 1'b0;
        end else if (an_n != '1) begin
            scan_live <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resume_seen <= 1'b0;
            stopped     <= 1'b0;
        end else begin
            resume_seen <= resume;
            if (core_en && halt) begin
                stopped <= 1'b1;
            end else if (resume && !resume_seen) begin
                stopped <= 1'b0;
            end
        end
    end

    halted_no_step: assert property (
        @(posedge clk) disable iff (rst) stopped |-> !core_en
    ) else $error("core enable high while halted");

    one_digit_lit: assert property (
        @(posedge clk) disable iff (rst) (scan_live || an_n != '1) |-> $onehot(~an_n)
    ) else $error("anode drive is not a single active digit");

    halt_gap: assert property (
        @(posedge clk) disable iff (rst) (core_en && halt) |=> !core_en [*2]
    ) else $error("core enable within two cycles of a halt step");

endmodule

// ==============================
// attach to the DUT blocks
// ==============================
bind run_control perf_board_props i_run_props (
    .clk     (clk),
    .rst     (rst),
    .core_en (core_en),
    .halt    (halt),
    .resume  (resume),
    .an_n    (8'hff)           // no display here
);

bind seg_display perf_board_props i_scan_props (
    .clk     (clk),
    .rst     (rst),
    .core_en (1'b0),
    .halt    (1'b0),
    .resume  (1'b0),
    .an_n    (an_n)
);

/* perf_board_top.sv */
module perf_board_top
    import perf_board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        resume,
    input  logic [15:0] swt,
    input  logic        halt,
    input  logic        is_jump,
    input  logic        is_branch,
    input  logic        taken,
    input  logic        is_nop,
    input  logic        bp_hit,
    input  logic        bp_miss,
    input  word_t       core_display,
    output logic        core_en,
    output seg_t        seg_n,
    output seg_t        an_n
);

    rate_sel_t rate_sel;
    disp_sel_t disp_sel;
    logic      tick;
    word_t     cnt_cycle;
    word_t     cnt_jump;
    word_t     cnt_branch;
    word_t     cnt_taken;
    word_t     cnt_nop;
    word_t     cnt_bp_hit;
    word_t     cnt_bp_miss;

    assign rate_sel = swt[1:0];
    assign disp_sel = swt[5:2];    // upper switches spare

    // ==============================
    // run control
    // ==============================
    rate_divider i_rate_divider (
        .clk      (clk),
        .rst      (rst),
        .rate_sel (rate_sel),
        .tick     (tick)
    );

    run_control i_run_control (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .halt    (halt),
        .resume  (resume),
        .core_en (core_en)
    );

    // ==============================
    // counters and display
    // ==============================
    event_counters i_event_counters (
        .clk         (clk),
        .rst         (rst),
        .core_en     (core_en),
        .is_jump     (is_jump),
        .is_branch   (is_branch),
        .taken       (taken),
        .is_nop      (is_nop),
        .bp_hit      (bp_hit),
        .bp_miss     (bp_miss),
        .cnt_cycle   (cnt_cycle),
        .cnt_jump    (cnt_jump),
        .cnt_branch  (cnt_branch),
        .cnt_taken   (cnt_taken),
        .cnt_nop     (cnt_nop),
        .cnt_bp_hit  (cnt_bp_hit),
        .cnt_bp_miss (cnt_bp_miss)
    );

    seg_display i_seg_display (
        .clk          (clk),
        .rst          (rst),
        .disp_sel     (disp_sel),
        .core_display (core_display),
        .cnt_cycle    (cnt_cycle),
        .cnt_jump     (cnt_jump),
        .cnt_branch   (cnt_branch),
        .cnt_taken    (cnt_taken),
        .cnt_nop      (cnt_nop),
        .cnt_bp_hit   (cnt_bp_hit),
        .cnt_bp_miss  (cnt_bp_miss),
        .seg_n        (seg_n),
        .an_n         (an_n)
    );

endmodule

/* seg_display.sv */
module seg_display
    import perf_board_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  disp_sel_t disp_sel,
    input  word_t     core_display,
    input  word_t     cnt_cycle,
    input  word_t     cnt_jump,
    input  word_t     cnt_branch,
    input  word_t     cnt_taken,
    input  word_t     cnt_nop,
    input  word_t     cnt_bp_hit,
    input  word_t     cnt_bp_miss,
    output seg_t      seg_n,
    output seg_t      an_n
);

    word_t                 disp_word;
    scan_cnt_t             pre;
    digit_idx_t            digit;
    logic                  load;
    nibble_t               nib;
    logic [6:0]            seg_on;     // gfedcba, active high
    logic [NUM_DIGITS-1:0] an_sel;

    // ==============================
    // source select
    // ==============================
    always_comb begin
        case (disp_sel)
            DISP_CORE:    disp_word = core_display;
            DISP_CYCLE:   disp_word = cnt_cycle;
            DISP_JUMP:    disp_word = cnt_jump;
            DISP_BRANCH:  disp_word = cnt_branch;
            DISP_TAKEN:   disp_word = cnt_taken;
            DISP_NOP:     disp_word = cnt_nop;
            DISP_BP_HIT:  disp_word = cnt_bp_hit;
            DISP_BP_MISS: disp_word = cnt_bp_miss;
            default:      disp_word = core_display;
        endcase
    end

    // ==============================
    // scan timing
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            pre   <= '0;
            digit <= digit_idx_t'(NUM_DIGITS - 1);   // first advance lands on digit 0
            load  <= 1'b0;
        end else begin
            load <= 1'b0;
            if (pre == scan_cnt_t'(DIGIT_PERIOD - 1)) begin
                pre  <= '0;
                load <= 1'b1;
                if (digit == digit_idx_t'(NUM_DIGITS - 1)) begin
                    digit <= '0;
                end else begin
                    digit <= digit + 1'b1;
                end
            end else begin
                pre <= pre + 1'b1;
            end
        end
    end

    assign nib = disp_word[{digit, 2'b00} +: 4];

    always_comb begin
        an_sel        = '0;
        an_sel[digit] = 1'b1;
    end

    always_comb begin
        case (nib)
            4'h0: seg_on = 7'h3f;
            4'h1: seg_on = 7'h06;
            4'h2: seg_on = 7'h5b;
            4'h3: seg_on = 7'h4f;
            4'h4: seg_on = 7'h66;
            4'h5: seg_on = 7'h6d;
            4'h6: seg_on = 7'h7d;
            4'h7: seg_on = 7'h07;
            4'h8: seg_on = 7'h7f;
            4'h9: seg_on = 7'h6f;
            4'ha: seg_on = 7'h77;
            4'hb: seg_on = 7'h7c;
            4'hc: seg_on = 7'h39;
            4'hd: seg_on = 7'h5e;
            4'he: seg_on = 7'h79;
            default: seg_on = 7'h71;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            seg_n <= '1;
            an_n  <= '1;                       // all digits dark
        end else if (load) begin
            seg_n <= {1'b1, ~seg_on};          // dp off
            an_n  <= ~an_sel;
        end
    end

endmodule

/* event_counters.sv */
module event_counters
    import perf_board_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  core_en,
    input  logic  is_jump,
    input  logic  is_branch,
    input  logic  taken,
    input  logic  is_nop,
    input  logic  bp_hit,
    input  logic  bp_miss,
    output word_t cnt_cycle,
    output word_t cnt_jump,
    output word_t cnt_branch,
    output word_t cnt_taken,
    output word_t cnt_nop,
    output word_t cnt_bp_hit,
    output word_t cnt_bp_miss
);

    logic [NUM_COUNTERS-1:0] hit;
    word_t                   cnt [NUM_COUNTERS];

    // slot 0 is the cycle counter, always hit on a step
    assign hit = {
        bp_miss,
        bp_hit,
        is_nop,
        taken,
        is_branch,
        is_jump,
        1'b1
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                cnt[i] <= '0;
            end
        end else if (core_en) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                if (hit[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;   // wraps at 2**32
                end
            end
        end
    end

    // ==============================
    // outputs
    // ==============================
    assign cnt_cycle   = cnt[0];
    assign cnt_jump    = cnt[1];
    assign cnt_branch  = cnt[2];
    assign cnt_taken   = cnt[3];
    assign cnt_nop     = cnt[4];
    assign cnt_bp_hit  = cnt[5];
    assign cnt_bp_miss = cnt[6];

endmodule

/* run_control.sv */
module run_control
    import perf_board_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic halt,
    input  logic resume,
    output logic core_en
);

    run_state_t state;
    run_state_t state_nxt;
    logic       resume_q;
    logic       resume_rise;

    // ==============================
    // step gating
    // ==============================
    assign core_en     = (state == st_run) && tick;
    assign resume_rise = resume && !resume_q;   // held button counts once

    // ==============================
    // run / halt FSM
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            st_run: begin
                if (core_en && halt) begin
                    state_nxt = st_halted;      // halt only seen on a real step
                end
            end
            st_halted: begin
                if (resume_rise) begin
                    state_nxt = st_run;
                end
            end
            default: begin
                state_nxt = st_run;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_run;
            resume_q <= 1'b0;
        end else begin
            state    <= state_nxt;
            resume_q <= resume;
        end
    end

endmodule

/* rate_divider.sv */
module rate_divider
    import perf_board_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rate_sel_t rate_sel,
    output logic      tick
);

    rate_sel_t sel_q;
    rate_cnt_t cnt;
    rate_cnt_t reload;
    logic      sel_change;

    always_comb begin
        case (rate_sel)
            2'd0:    reload = rate_cnt_t'(RATE_PERIOD_0 - 1);
            2'd1:    reload = rate_cnt_t'(RATE_PERIOD_1 - 1);
            2'd2:    reload = rate_cnt_t'(RATE_PERIOD_2 - 1);
            default: reload = rate_cnt_t'(RATE_PERIOD_3 - 1);
        endcase
    end

    assign sel_change = (rate_sel != sel_q);   // switches moved

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= rate_sel;
            cnt   <= reload;
            tick  <= 1'b0;
        end else begin
            sel_q <= rate_sel;
            if (sel_change || cnt == '0) begin
                cnt <= reload;                 // restart full period
            end else begin
                cnt <= cnt - 1'b1;
            end
            tick <= !sel_change && (cnt == '0);
        end
    end

endmodule

/* perf_board_pkg.sv */
package perf_board_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int WORD_W       = 32;
    localparam int NUM_DIGITS   = 8;
    localparam int NUM_COUNTERS = 7;    // cycle plus six event kinds

    // ==============================
    // timing
    // ==============================
    localparam int RATE_PERIOD_0 = 64;  // slowest step rate
    localparam int RATE_PERIOD_1 = 16;
    localparam int RATE_PERIOD_2 = 4;
    localparam int RATE_PERIOD_3 = 1;   // step every clk
    localparam int DIGIT_PERIOD  = 8;   // clk cycles per lit digit

    localparam int RATE_CNT_W  = $clog2(RATE_PERIOD_0);
    localparam int SCAN_CNT_W  = $clog2(DIGIT_PERIOD);
    localparam int DIGIT_IDX_W = $clog2(NUM_DIGITS);

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [1:0]             rate_sel_t;
    typedef logic [3:0]             disp_sel_t;
    typedef logic [RATE_CNT_W-1:0]  rate_cnt_t;
    typedef logic [SCAN_CNT_W-1:0]  scan_cnt_t;
    typedef logic [DIGIT_IDX_W-1:0] digit_idx_t;
    typedef logic [3:0]             nibble_t;
    typedef logic [7:0]             seg_t;

    // ==============================
    // display select codes
    // ==============================
    localparam disp_sel_t DISP_CORE    = 4'd0;
    localparam disp_sel_t DISP_CYCLE   = 4'd1;
    localparam disp_sel_t DISP_JUMP    = 4'd2;
    localparam disp_sel_t DISP_BRANCH  = 4'd3;
    localparam disp_sel_t DISP_TAKEN   = 4'd4;
    localparam disp_sel_t DISP_NOP     = 4'd5;
    localparam disp_sel_t DISP_BP_HIT  = 4'd6;
    localparam disp_sel_t DISP_BP_MISS = 4'd7;  // 8..15 fall back to core word

    typedef enum logic {
        st_run,
        st_halted
    } run_state_t;

endpackage
